// ==== Bender.yml ====
package:
  name: conv5x5_engine

sources:
  - files:
      - hw/conv_pkg.sv
      - hw/conv_cmd_decode.sv
      - hw/conv_window.sv
      - hw/conv_mac_tree.sv
      - hw/conv_result.sv
      - hw/conv_top.sv
  - target: simulation
    files:
      - tb/conv_tb.sv

// ==== build.f ====
hw/conv_pkg.sv
hw/conv_cmd_decode.sv
hw/conv_window.sv
hw/conv_mac_tree.sv
hw/conv_result.sv
hw/conv_top.sv
tb/conv_tb.sv

// ==== hw/conv_cmd_decode.sv ====
`default_nettype none

module conv_cmd_decode (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        cmd_valid,
  input  conv_pkg::conv_op_e          cmd_op,
  input  logic [conv_pkg::DATA_W-1:0] cmd_data,
  output conv_pkg::kernel_t           kernel,
  output logic                        pix_strobe,
  output logic [conv_pkg::DATA_W-1:0] pix_data,
  output logic                        frame_clear
);

  import conv_pkg::*;

  localparam int PTR_W = $clog2(KTAPS);

  logic [PTR_W-1:0] w_ptr;
  logic             w_last;
  logic             is_pixel;

  assign w_last   = (w_ptr == PTR_W'(KTAPS - 1));
  assign is_pixel = cmd_valid && (cmd_op == OP_PIXEL);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      kernel      <= '0;
      w_ptr       <= '0;
      pix_strobe  <= 1'b0;
      frame_clear <= 1'b0;
    end else begin
      pix_strobe  <= is_pixel;
      frame_clear <= cmd_valid && (cmd_op == OP_CLEAR);
      if (cmd_valid) begin
        case (cmd_op)
          OP_LOAD_W: begin
            kernel[w_ptr] <= cmd_data;
            w_ptr         <= w_last ? '0 : w_ptr + 1'b1;  // 24 wraps to 0
          end
          OP_CLEAR: begin
            w_ptr <= '0;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // pixel payload, only meaningful with pix_strobe
  always_ff @(posedge clk) begin
    if (is_pixel) begin
      pix_data <= cmd_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/conv_mac_tree.sv ====
`default_nettype none

module conv_mac_tree (
  input  logic                       clk,
  input  logic                       arst_n,
  input  conv_pkg::window_t          window,
  input  logic                       win_valid,
  input  conv_pkg::kernel_t          kernel,
  output logic [conv_pkg::SUM_W-1:0] sum,
  output logic                       sum_valid
);

  import conv_pkg::*;

  localparam int PROD_W = 2 * DATA_W;
  localparam int L1_N   = (KTAPS + 1) / 2;  // 13
  localparam int L2_N   = (L1_N + 1) / 2;   // 7
  localparam int L3_N   = (L2_N + 1) / 2;   // 4

  logic [PROD_W-1:0] prod_q [KTAPS];
  logic [SUM_W-1:0]  lvl1   [L1_N];
  logic [SUM_W-1:0]  lvl2   [L2_N];
  logic [SUM_W-1:0]  lvl3   [L3_N];
  logic [SUM_W-1:0]  part_q [L3_N];
  logic [1:0]        vld_q;

  always_ff @(posedge clk) begin
    if (win_valid) begin
      for (int i = 0; i < KTAPS; i++) begin
        prod_q[i] <= window[i] * kernel[i];
      end
    end
  end

  // first three tree levels, odd leftovers pass straight up
  always_comb begin
    for (int i = 0; i < L1_N - 1; i++) begin
      lvl1[i] = SUM_W'(prod_q[2*i]) + SUM_W'(prod_q[2*i+1]);
    end
    lvl1[L1_N-1] = SUM_W'(prod_q[KTAPS-1]);
    for (int i = 0; i < L2_N - 1; i++) begin
      lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
    end
    lvl2[L2_N-1] = lvl1[L1_N-1];
    for (int i = 0; i < L3_N - 1; i++) begin
      lvl3[i] = lvl2[2*i] + lvl2[2*i+1];
    end
    lvl3[L3_N-1] = lvl2[L2_N-1];
  end

  always_ff @(posedge clk) begin
    if (vld_q[0]) begin
      part_q <= lvl3;
    end
  end

  // last two levels
  always_ff @(posedge clk) begin
    if (vld_q[1]) begin
      sum <= (part_q[0] + part_q[1]) + (part_q[2] + part_q[3]);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q     <= '0;
      sum_valid <= 1'b0;
    end else begin
      vld_q     <= {vld_q[0], win_valid};
      sum_valid <= vld_q[1];
    end
  end

endmodule

`default_nettype wire

// ==== hw/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

  localparam int KSIZE  = 5;
  localparam int KTAPS  = KSIZE * KSIZE;
  localparam int DATA_W = 8;
  localparam int SUM_W  = 18;  // wraps mod 2^18

  // index 0 is top-left, row by row
  typedef logic [KTAPS-1:0][DATA_W-1:0] kernel_t;
  typedef logic [KTAPS-1:0][DATA_W-1:0] window_t;

  typedef enum logic [1:0] {
    OP_NOP    = 2'd0,
    OP_LOAD_W = 2'd1,
    OP_PIXEL  = 2'd2,
    OP_CLEAR  = 2'd3
  } conv_op_e;

  typedef enum logic {
    ST_FILL = 1'b0,  // first four rows of a frame
    ST_EMIT = 1'b1
  } res_state_e;

endpackage

`default_nettype wire

// ==== hw/conv_result.sv ====
`default_nettype none

module conv_result #(
  parameter int IMG_W = 12,
  parameter int IMG_H = 10
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [conv_pkg::SUM_W-1:0] sum,
  input  logic                       sum_valid,
  input  logic                       frame_clear,
  output logic [conv_pkg::SUM_W-1:0] out_data,
  output logic                       out_valid,
  output logic                       frame_done
);

  import conv_pkg::*;

  localparam int COL_W = $clog2(IMG_W);
  localparam int ROW_W = $clog2(IMG_H);

  res_state_e       state;
  logic [COL_W-1:0] col;
  logic [ROW_W-1:0] row;
  logic             last_col;
  logic             last_row;
  logic             emit;

  assign last_col = (col == COL_W'(IMG_W - 1));
  assign last_row = (row == ROW_W'(IMG_H - 1));
  assign emit     = (state == ST_EMIT) && (col >= COL_W'(KSIZE - 1));  // interior only

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_FILL;
      col        <= '0;
      row        <= '0;
      out_valid  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      out_valid  <= sum_valid && emit;
      frame_done <= sum_valid && emit && last_row && last_col;
      if (frame_clear) begin
        state <= ST_FILL;
        col   <= '0;
        row   <= '0;
      end else if (sum_valid) begin
        if (last_col) begin
          col <= '0;
          row <= last_row ? '0 : row + 1'b1;
          if (last_row) begin
            state <= ST_FILL;  // next frame
          end else if (row == ROW_W'(KSIZE - 2)) begin
            state <= ST_EMIT;
          end
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid && emit) begin
      out_data <= sum;
    end
  end

endmodule

`default_nettype wire

// ==== hw/conv_top.sv ====
`default_nettype none

module conv_top #(
  parameter int IMG_W = 12,
  parameter int IMG_H = 10
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        cmd_valid,
  input  conv_pkg::conv_op_e          cmd_op,
  input  logic [conv_pkg::DATA_W-1:0] cmd_data,
  output logic [conv_pkg::SUM_W-1:0]  out_data,
  output logic                        out_valid,
  output logic                        frame_done
);

  import conv_pkg::*;

  kernel_t           kernel;
  window_t           window;
  logic              pix_strobe;
  logic [DATA_W-1:0] pix_data;
  logic              frame_clear;
  logic              win_valid;
  logic [SUM_W-1:0]  sum;
  logic              sum_valid;

  conv_cmd_decode u_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_data    (cmd_data),
    .kernel      (kernel),
    .pix_strobe  (pix_strobe),
    .pix_data    (pix_data),
    .frame_clear (frame_clear)
  );

  conv_window #(
    .IMG_W (IMG_W)
  ) u_window (
    .clk        (clk),
    .arst_n     (arst_n),
    .pix_strobe (pix_strobe),
    .pix_data   (pix_data),
    .window     (window),
    .win_valid  (win_valid)
  );

  conv_mac_tree u_mac_tree (
    .clk       (clk),
    .arst_n    (arst_n),
    .window    (window),
    .win_valid (win_valid),
    .kernel    (kernel),
    .sum       (sum),
    .sum_valid (sum_valid)
  );

  conv_result #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) u_result (
    .clk         (clk),
    .arst_n      (arst_n),
    .sum         (sum),
    .sum_valid   (sum_valid),
    .frame_clear (frame_clear),
    .out_data    (out_data),
    .out_valid   (out_valid),
    .frame_done  (frame_done)
  );

endmodule

`default_nettype wire

// ==== hw/conv_window.sv ====
`default_nettype none

module conv_window #(
  parameter int IMG_W = 12
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        pix_strobe,
  input  logic [conv_pkg::DATA_W-1:0] pix_data,
  output conv_pkg::window_t           window,
  output logic                        win_valid
);

  import conv_pkg::*;

  localparam int PTR_W  = $clog2(IMG_W);
  localparam int NLINES = KSIZE - 1;

  // four line buffers, each a circular buffer of one image row
  logic [DATA_W-1:0] lb_mem [NLINES][IMG_W];
  logic [PTR_W-1:0]  wr_ptr;

  // new right column of the window, index is window row
  logic [DATA_W-1:0] col_in [KSIZE];

  always_comb begin
    col_in[KSIZE-1] = pix_data;  // bottom row is the newest pixel
    for (int k = 0; k < NLINES; k++) begin
      col_in[KSIZE-2-k] = lb_mem[k][wr_ptr];  // k+1 rows up
    end
  end

  // each buffer takes the column entry one row below it
  always_ff @(posedge clk) begin
    if (pix_strobe) begin
      for (int k = 0; k < NLINES; k++) begin
        lb_mem[k][wr_ptr] <= col_in[KSIZE-1-k];
      end
    end
  end

  // delay stays one row no matter where the pointer starts
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
    end else if (pix_strobe) begin
      if (wr_ptr == PTR_W'(IMG_W - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pix_strobe) begin
      for (int r = 0; r < KSIZE; r++) begin
        for (int c = 0; c < KSIZE - 1; c++) begin
          window[r*KSIZE+c] <= window[r*KSIZE+c+1];  // shift left
        end
        window[r*KSIZE+KSIZE-1] <= col_in[r];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      win_valid <= 1'b0;
    end else begin
      win_valid <= pix_strobe;  // every shift, border or not
    end
  end

endmodule

`default_nettype wire

// ==== tb/conv_tb.sv ====
`default_nettype none

module conv_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import conv_pkg::*;

  localparam int IMG_W  = 12;
  localparam int IMG_H  = 10;
  localparam int NPIX   = IMG_W * IMG_H;
  localparam int CLK_P  = 100;
  localparam int SEED   = 35713;
  localparam int N_CMDS = 6 * KTAPS + 8 + 6 * NPIX * 3;  // pixels count with worst-case gaps

  typedef logic [NPIX-1:0][DATA_W-1:0] image_t;

  logic              clk = 1'b0;
  logic              arst_n;
  logic              cmd_valid;
  conv_op_e          cmd_op;
  logic [DATA_W-1:0] cmd_data;
  logic [SUM_W-1:0]  out_data;
  logic              out_valid;
  logic              frame_done;

  kernel_t           wts;
  image_t            img;
  bit                gaps_on;
  logic [SUM_W-1:0]  exp_data_q [$];
  bit                exp_done_q [$];
  longint            exp_time_q [$];  // edge that sampled the pixel

  conv_top #(.IMG_W(IMG_W), .IMG_H(IMG_H)) uut (
    .clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .cmd_data(cmd_data), .out_data(out_data), .out_valid(out_valid),
    .frame_done(frame_done)
  );

  always #(CLK_P / 2) clk = ~clk;

  // 5x5 neighbourhood ending at (r, c), wrapped to SUM_W bits
  function automatic logic [SUM_W-1:0] conv_ref(input kernel_t w, input image_t im,
                                                input int r, input int c);
    int acc;
    acc = 0;
    for (int i = 0; i < KSIZE; i++) begin
      for (int j = 0; j < KSIZE; j++) begin
        acc += int'(w[i*KSIZE+j]) * int'(im[(r-4+i)*IMG_W + (c-4+j)]);
      end
    end
    return SUM_W'(acc);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act));
    end
  endtask

  task automatic send_cmd(input conv_op_e op, input logic [DATA_W-1:0] data);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_data  <= data;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      cmd_valid <= 1'b0;
      cmd_op    <= conv_op_e'(2'($urandom_range(0, 3)));  // must be ignored
      cmd_data  <= DATA_W'($urandom);
    end
  endtask

  task automatic push_pixel(input int r, input int c, input logic [DATA_W-1:0] pix);
    int gap;
    gap = gaps_on ? $urandom_range(0, 2) : 0;
    repeat (gap) begin
      if ($urandom_range(0, 1) == 1) send_cmd(OP_NOP, DATA_W'($urandom));
      else idle_cycles(1);
    end
    img[r*IMG_W+c] = pix;
    send_cmd(OP_PIXEL, pix);
    if (r >= KSIZE - 1 && c >= KSIZE - 1) begin
      exp_data_q.push_back(conv_ref(wts, img, r, c));
      exp_done_q.push_back(r == IMG_H - 1 && c == IMG_W - 1);
      exp_time_q.push_back(longint'($time) + CLK_P);
    end
  endtask

  // kind 0 ramp, 1 random, 2 all 255
  task automatic send_frame(input int kind, input int npix);
    logic [DATA_W-1:0] v;
    for (int p = 0; p < npix; p++) begin
      case (kind)
        0:       v = DATA_W'(p);
        1:       v = DATA_W'($urandom_range(0, 255));
        default: v = 8'hff;
      endcase
      push_pixel(p / IMG_W, p % IMG_W, v);
    end
  endtask

  task automatic load_weights(input int kind);
    logic [DATA_W-1:0] v;
    for (int i = 0; i < KTAPS; i++) begin
      case (kind)
        0:       v = 8'd1;
        1:       v = DATA_W'($urandom_range(0, 255));
        default: v = 8'hff;
      endcase
      wts[i] = v;
      send_cmd(OP_LOAD_W, v);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_data_q.size() != 0 && n < 10) begin
      idle_cycles(1);
      n++;
    end
    if (exp_data_q.size() != 0) begin
      abort_run($sformatf("missing output: %0d expected results never came out",
                          exp_data_q.size()));
    end
    idle_cycles(3);
  endtask

  always @(negedge clk) begin
    if (arst_n && out_valid) begin
      if (exp_data_q.size() == 0) begin
        abort_run($sformatf("extra output: out_valid at %0t with nothing expected", $time));
      end
      check_val("out_data", 32'(exp_data_q.pop_front()), 32'(out_data));
      check_val("frame_done", 32'(exp_done_q.pop_front()), 32'(frame_done));
      check_val("out_valid latency", 32'd5,
                32'((longint'($time) - CLK_P / 2 - exp_time_q.pop_front()) / CLK_P));
    end else if (arst_n) begin
      check_val("frame_done", 32'd0, 32'(frame_done));  // only with out_valid
    end
  end

  initial begin
    #((N_CMDS * 4 + 100) * CLK_P);
    $display("timeout: the run did not finish in time");
    $display("TB FAILED");
    $fatal(1);
  end

  initial begin
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = OP_NOP;
    cmd_data  = '0;
    wts       = '0;
    img       = '0;
    gaps_on   = 1'b0;
    void'($urandom(SEED));
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    idle_cycles(2);

    load_weights(0);  // all ones, ramp image
    send_frame(0, NPIX);
    wait_drain();

    load_weights(1);
    gaps_on = 1'b1;
    send_frame(1, NPIX);  // two frames back to back
    send_frame(1, NPIX);
    wait_drain();

    gaps_on = 1'b0;
    load_weights(2);  // wrap check
    send_frame(2, NPIX);
    wait_drain();

    gaps_on = 1'b1;
    load_weights(1);
    send_frame(1, 5 * IMG_W + 3);  // abandoned mid-frame
    wait_drain();
    repeat (7) send_cmd(OP_LOAD_W, DATA_W'($urandom));  // leaves pointer at 7
    send_cmd(OP_CLEAR, '0);
    load_weights(1);
    send_frame(1, NPIX);
    wait_drain();
    idle_cycles(10);

    if (exp_data_q.size() != 0) begin
      abort_run("missing output at end of run");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
